// ==== hw/core_pkg.sv ====
// core pipeline definitions
package core_pkg;

    // opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // r-type function codes
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    // one instruction word, two readings
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } inst_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex,
        fwd_mem
    } forward_type_t;

    typedef struct packed {
        logic [31:0] pc;
        inst_t       inst;  // zero word is a nop
    } if_regs_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] a_data;
        logic [31:0] b_data;
        logic [31:0] imm;  // sign-extended
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  w_regnum;
        alu_op_t     alu_op;
        logic        b_is_reg;
        logic        write_enable;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
    } id_regs_t;

    typedef struct packed {
        logic [31:0] out;
        logic [31:0] b_data;
        logic [4:0]  w_regnum;
        logic        write_enable;
        logic        mem_read;
        logic        mem_write;
    } ex_regs_t;

    typedef struct packed {
        logic [31:0] w_data;
        logic [4:0]  w_regnum;
        logic        write_enable;
    } mem_regs_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;
    } dbus_req_t;

endpackage

// ==== hw/core_if.sv ====
// instruction fetch stage
`timescale 1ns/1ns

module core_if (
    input  logic               clock,
    input  logic               rst_n,
    input  logic [31:0]        next_fetch_pc,
    input  logic               stall,
    input  logic               flush,
    output logic [31:0]        inst_addr,
    input  logic [31:0]        inst_rdata,
    output core_pkg::if_regs_t if_regs
);
    logic [31:0] pc;

    assign inst_addr = pc;  // word comes back in the same cycle

    // next_fetch_pc is pc + 4 unless a branch redirects
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (flush || !stall) begin
            pc <= next_fetch_pc;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            if_regs <= '0;
        end else if (flush) begin
            if_regs <= '0;  // squashed slot becomes a nop
        end else if (!stall) begin
            if_regs.pc   <= pc;
            if_regs.inst <= inst_rdata;
        end
    end

endmodule

// ==== hw/core_id.sv ====
// decode stage and register file
`timescale 1ns/1ns

module core_id (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                mem_stall,
    input  logic                flush,
    input  core_pkg::if_regs_t  if_regs,
    input  core_pkg::mem_regs_t mem_regs,
    output core_pkg::id_regs_t  id_regs,
    output logic                b_is_reg  // slot in decode reads rt
);
    logic [31:0]        regs [32];
    core_pkg::inst_t    inst;
    core_pkg::id_regs_t decoded;
    logic [4:0]         rs, rt;

    // r0 reads zero, a same-cycle writeback passes through
    function automatic logic [31:0] read_port(input logic [4:0] num, input logic [31:0] entry,
                                              input core_pkg::mem_regs_t wb);
        if (num == 5'd0)
            return '0;
        if (wb.write_enable && wb.w_regnum == num)
            return wb.w_data;
        return entry;
    endfunction

    assign inst     = if_regs.inst;
    assign rs       = inst.i_fields.rs;
    assign rt       = inst.i_fields.rt;
    assign b_is_reg = decoded.b_is_reg;

    always_comb begin
        decoded          = '0;
        decoded.pc       = if_regs.pc;
        decoded.rs       = rs;
        decoded.rt       = rt;
        decoded.a_data   = read_port(rs, regs[rs], mem_regs);
        decoded.b_data   = read_port(rt, regs[rt], mem_regs);
        decoded.imm      = {{16{inst.i_fields.imm16[15]}}, inst.i_fields.imm16};
        decoded.w_regnum = rt;
        case (inst.i_fields.op)
            core_pkg::op_rtype: begin
                decoded.w_regnum     = inst.r_fields.rd;
                decoded.b_is_reg     = 1'b1;
                decoded.write_enable = 1'b1;
                case (inst.r_fields.funct)
                    core_pkg::fn_addu: decoded.alu_op = core_pkg::alu_add;
                    core_pkg::fn_subu: decoded.alu_op = core_pkg::alu_sub;
                    core_pkg::fn_and:  decoded.alu_op = core_pkg::alu_and;
                    core_pkg::fn_or:   decoded.alu_op = core_pkg::alu_or;
                    core_pkg::fn_slt:  decoded.alu_op = core_pkg::alu_slt;
                    default: begin  // unknown funct, nop
                        decoded.b_is_reg     = 1'b0;
                        decoded.write_enable = 1'b0;
                    end
                endcase
            end
            core_pkg::op_addiu: decoded.write_enable = 1'b1;
            core_pkg::op_lw: begin
                decoded.write_enable = 1'b1;
                decoded.mem_read     = 1'b1;
            end
            core_pkg::op_sw: begin
                decoded.b_is_reg  = 1'b1;  // store data
                decoded.mem_write = 1'b1;
            end
            core_pkg::op_beq: begin
                decoded.b_is_reg = 1'b1;
                decoded.branch   = 1'b1;
            end
            default: ;  // anything else is a nop
        endcase
        if (decoded.w_regnum == 5'd0)
            decoded.write_enable = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (mem_regs.write_enable)
            regs[mem_regs.w_regnum] <= mem_regs.w_data;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            id_regs <= '0;
        end else if (mem_stall) begin
            // held slot picks up the writeback it would have forwarded
            id_regs.a_data <= read_port(id_regs.rs, id_regs.a_data, mem_regs);
            id_regs.b_data <= read_port(id_regs.rt, id_regs.b_data, mem_regs);
        end else if (stall || flush) begin
            id_regs <= '0;  // bubble
        end else begin
            id_regs <= decoded;
        end
    end

    // decode never lets a write to r0 reach writeback
    assert property (@(posedge clock) disable iff (!rst_n)
        mem_regs.write_enable |-> mem_regs.w_regnum != 5'd0);

endmodule

// ==== hw/core_ex.sv ====
// execute stage with forwarding muxes and alu
`timescale 1ns/1ns

module core_ex (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    mem_stall,
    input  core_pkg::id_regs_t      id_regs,
    input  core_pkg::forward_type_t forward_a,
    input  core_pkg::forward_type_t forward_b,
    input  core_pkg::mem_regs_t     mem_regs,
    output core_pkg::ex_regs_t      ex_regs,
    output logic [31:0]             op_a,
    output logic [31:0]             op_b
);
    logic [31:0] alu_b, alu_out;

    always_comb begin
        case (forward_a)
            core_pkg::fwd_ex:  op_a = ex_regs.out;
            core_pkg::fwd_mem: op_a = mem_regs.w_data;
            default:           op_a = id_regs.a_data;
        endcase
        case (forward_b)
            core_pkg::fwd_ex:  op_b = ex_regs.out;
            core_pkg::fwd_mem: op_b = mem_regs.w_data;
            default:           op_b = id_regs.b_data;
        endcase
    end

    // sw reads rt for data only, address uses imm
    assign alu_b = (id_regs.b_is_reg && !id_regs.mem_write) ? op_b : id_regs.imm;

    always_comb begin
        case (id_regs.alu_op)
            core_pkg::alu_sub: alu_out = op_a - alu_b;
            core_pkg::alu_and: alu_out = op_a & alu_b;
            core_pkg::alu_or:  alu_out = op_a | alu_b;
            core_pkg::alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            default:           alu_out = op_a + alu_b;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_regs <= '0;
        end else if (!mem_stall) begin
            ex_regs.out          <= alu_out;
            ex_regs.b_data       <= op_b;  // forwarded store data
            ex_regs.w_regnum     <= id_regs.w_regnum;
            ex_regs.write_enable <= id_regs.write_enable;
            ex_regs.mem_read     <= id_regs.mem_read;
            ex_regs.mem_write    <= id_regs.mem_write;
        end
    end

endmodule

// ==== hw/core_branch.sv ====
// beq resolution and fetch redirect
`timescale 1ns/1ns

module core_branch (
    input  core_pkg::id_regs_t id_regs,
    input  logic [31:0]        op_a,
    input  logic [31:0]        op_b,
    input  logic [31:0]        if_pc,
    input  logic               mem_stall,
    output logic [31:0]        next_fetch_pc,
    output logic               flush
);
    logic        taken;
    logic [31:0] target;

    assign taken  = id_regs.branch && (op_a == op_b);  // operands already forwarded
    assign target = id_regs.pc + 32'd4 + {id_regs.imm[29:0], 2'b00};

    // wait for the memory stall to clear before redirecting
    assign flush = taken && !mem_stall;

    assign next_fetch_pc = flush ? target : if_pc + 32'd4;

endmodule

// ==== hw/core_forward.sv ====
// operand forwarding select
`timescale 1ns/1ns

module core_forward (
    input  logic [4:0]              id_rs,
    input  logic [4:0]              id_rt,
    input  logic                    id_b_is_reg,
    input  core_pkg::ex_regs_t      ex_regs,
    input  core_pkg::mem_regs_t     mem_regs,
    output core_pkg::forward_type_t forward_a,
    output core_pkg::forward_type_t forward_b
);
    logic ex_fwd_ok, mem_fwd_ok;

    // load data is not ready in ex_regs
    assign ex_fwd_ok  = ex_regs.write_enable && !ex_regs.mem_read && ex_regs.w_regnum != 5'd0;
    assign mem_fwd_ok = mem_regs.write_enable && mem_regs.w_regnum != 5'd0;

    always_comb begin
        forward_a = core_pkg::fwd_none;
        forward_b = core_pkg::fwd_none;
        if (ex_fwd_ok && ex_regs.w_regnum == id_rs)
            forward_a = core_pkg::fwd_ex;  // youngest wins
        else if (mem_fwd_ok && mem_regs.w_regnum == id_rs)
            forward_a = core_pkg::fwd_mem;
        if (id_b_is_reg) begin
            if (ex_fwd_ok && ex_regs.w_regnum == id_rt)
                forward_b = core_pkg::fwd_ex;
            else if (mem_fwd_ok && mem_regs.w_regnum == id_rt)
                forward_b = core_pkg::fwd_mem;
        end
    end

endmodule

// ==== hw/core_hazard.sv ====
// load-use and front-end stall
`timescale 1ns/1ns

module core_hazard (
    input  core_pkg::if_regs_t if_regs,
    input  logic               if_b_is_reg,
    input  core_pkg::id_regs_t id_regs,
    input  logic               mem_stall,
    output logic               stall
);
    logic [4:0] if_rs, if_rt;
    logic       load_use;

    assign if_rs = if_regs.inst.r_fields.rs;
    assign if_rt = if_regs.inst.r_fields.rt;

    always_comb begin
        load_use = 1'b0;
        if (id_regs.mem_read && id_regs.w_regnum != 5'd0) begin
            if (id_regs.w_regnum == if_rs)
                load_use = 1'b1;
            if (if_b_is_reg && id_regs.w_regnum == if_rt)
                load_use = 1'b1;
        end
    end

    assign stall = load_use || mem_stall;

endmodule

// ==== hw/core_mem.sv ====
// memory stage and data port
`timescale 1ns/1ns

module core_mem (
    input  logic                clock,
    input  logic                rst_n,
    input  core_pkg::ex_regs_t  ex_regs,
    output core_pkg::dbus_req_t d_req,
    output logic                d_valid,
    input  logic                d_ready,
    input  logic [31:0]         d_rdata,
    output logic                mem_stall,
    output core_pkg::mem_regs_t mem_regs
);
    assign d_req.addr  = ex_regs.out;
    assign d_req.wdata = ex_regs.b_data;
    assign d_req.write = ex_regs.mem_write;

    assign d_valid   = ex_regs.mem_read || ex_regs.mem_write;
    assign mem_stall = d_valid && !d_ready;  // wait for the handshake

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mem_regs <= '0;
        end else if (mem_stall) begin
            mem_regs <= '0;  // bubble while the access is pending
        end else begin
            mem_regs.w_data       <= ex_regs.mem_read ? d_rdata : ex_regs.out;
            mem_regs.w_regnum     <= ex_regs.w_regnum;
            mem_regs.write_enable <= ex_regs.write_enable;
        end
    end

    // the pipeline holds ex_regs, so a pending request must not move
    assert property (@(posedge clock) disable iff (!rst_n)
        d_valid && !d_ready |=> d_valid && $stable(d_req));

endmodule

// ==== hw/core.sv ====
// five stage mips core
`timescale 1ns/1ns

module core (
    input  logic                clock,
    input  logic                rst_n,

    // instruction port, combinational
    output logic [31:0]         inst_addr,
    input  logic [31:0]         inst_rdata,

    // data port
    output core_pkg::dbus_req_t d_req,
    output logic                d_valid,  // access pending
    input  logic                d_ready,  // access completes this cycle
    input  logic [31:0]         d_rdata
);
    core_pkg::if_regs_t      if_regs;
    core_pkg::id_regs_t      id_regs;
    core_pkg::ex_regs_t      ex_regs;
    core_pkg::mem_regs_t     mem_regs;
    core_pkg::forward_type_t forward_a, forward_b;

    logic        stall, flush, mem_stall, b_is_reg;
    logic [31:0] next_fetch_pc, op_a, op_b;

    core_if if_stage (
        .clock(clock),
        .rst_n(rst_n),
        .next_fetch_pc(next_fetch_pc),
        .stall(stall),
        .flush(flush),
        .inst_addr(inst_addr),
        .inst_rdata(inst_rdata),
        .if_regs(if_regs)
    );

    core_id id_stage (
        .clock(clock),
        .rst_n(rst_n),
        .stall(stall),
        .mem_stall(mem_stall),
        .flush(flush),
        .if_regs(if_regs),
        .mem_regs(mem_regs),
        .id_regs(id_regs),
        .b_is_reg(b_is_reg)
    );

    core_ex ex_stage (
        .clock(clock),
        .rst_n(rst_n),
        .mem_stall(mem_stall),
        .id_regs(id_regs),
        .forward_a(forward_a),
        .forward_b(forward_b),
        .mem_regs(mem_regs),
        .ex_regs(ex_regs),
        .op_a(op_a),
        .op_b(op_b)
    );

    core_branch branch_unit (
        .id_regs(id_regs),
        .op_a(op_a),
        .op_b(op_b),
        .if_pc(inst_addr),  // fetch pc of the current slot
        .mem_stall(mem_stall),
        .next_fetch_pc(next_fetch_pc),
        .flush(flush)
    );

    core_forward forward_unit (
        .id_rs(id_regs.rs),
        .id_rt(id_regs.rt),
        .id_b_is_reg(id_regs.b_is_reg),
        .ex_regs(ex_regs),
        .mem_regs(mem_regs),
        .forward_a(forward_a),
        .forward_b(forward_b)
    );

    core_hazard hazard_unit (
        .if_regs(if_regs),
        .if_b_is_reg(b_is_reg),
        .id_regs(id_regs),
        .mem_stall(mem_stall),
        .stall(stall)
    );

    core_mem mem_stage (
        .clock(clock),
        .rst_n(rst_n),
        .ex_regs(ex_regs),
        .d_req(d_req),
        .d_valid(d_valid),
        .d_ready(d_ready),
        .d_rdata(d_rdata),
        .mem_stall(mem_stall),
        .mem_regs(mem_regs)
    );

endmodule

// ==== tests/tb_core.sv ====
// testbench for the core pipeline
`timescale 1ns/1ns

module tb_core;
    logic                clock;
    logic                rst_n;
    logic [31:0]         inst_addr;
    logic [31:0]         inst_rdata;
    core_pkg::dbus_req_t d_req;
    logic                d_valid;
    logic                d_ready;
    logic [31:0]         d_rdata;

    logic [31:0] rom [256];        // slots 0..199 hold the program
    logic [31:0] dmem [128];       // memory seen by the port
    logic [31:0] model_mem [128];  // memory of the reference model
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    integer      seed;

    core core_inst (
        .clock(clock),
        .rst_n(rst_n),
        .inst_addr(inst_addr),
        .inst_rdata(inst_rdata),
        .d_req(d_req),
        .d_valid(d_valid),
        .d_ready(d_ready),
        .d_rdata(d_rdata)
    );

    always #5 clock = ~clock;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // every bit of the word index shows up in the pattern
    function automatic logic [31:0] fill_word(input logic [6:0] idx);
        return {idx, 9'h0a5, idx, 9'h15a};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] funct);
        return {core_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [5:0] pick_funct();
        case (rand_below(5))
            0: return core_pkg::fn_addu;
            1: return core_pkg::fn_subu;
            2: return core_pkg::fn_and;
            3: return core_pkg::fn_or;
            default: return core_pkg::fn_slt;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic put(input int slot, input logic [31:0] word);
        rom[slot[7:0]] = word;
    endtask

    // init r1..r7, random body up to slot 191, final stores, then a self loop at 199
    task automatic build_program();
        logic [4:0] rs, src2, rd;
        int         kind, skip;
        rom = '{default: 32'd0};
        for (int r = 1; r <= 7; r++)
            put(r - 1, i_word(core_pkg::op_addiu, 5'd0, r[4:0], 16'(rand_below(128)) - 16'd64));
        for (int s = 7; s < 192; s++) begin
            kind = int'(rand_below(10));
            rs   = 5'(rand_below(8));
            src2 = 5'(rand_below(8));
            rd   = 5'(1 + rand_below(7));
            if (kind < 3) begin
                put(s, r_word(rs, src2, rd, pick_funct()));
            end else if (kind < 5) begin
                put(s, i_word(core_pkg::op_addiu, rs, rd, 16'(rand_below(128)) - 16'd64));
            end else if (kind < 7) begin
                put(s, i_word(core_pkg::op_lw, 5'd0, rd, 16'(rand_below(64) * 4)));
            end else if (kind < 9) begin
                put(s, i_word(core_pkg::op_sw, 5'd0, src2, 16'(rand_below(64) * 4)));
            end else begin
                skip = int'(rand_below(4));
                if (s + 1 + skip > 192)
                    skip = 191 - s;  // land no further than the first final store
                if (rand_below(2) == 0)
                    src2 = rs;  // equal registers, always taken
                put(s, i_word(core_pkg::op_beq, rs, src2, 16'(skip)));
            end
        end
        for (int r = 1; r <= 7; r++)
            put(191 + r, i_word(core_pkg::op_sw, 5'd0, r[4:0], 16'(256 + 4 * r)));
        put(199, i_word(core_pkg::op_beq, 5'd0, 5'd0, 16'hffff));
    endtask

    // runs the program one instruction at a time and queues the stores it makes
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] word, a, b, imm, res, addr;
        logic [4:0]  rs, rt, rd;
        int          pc_idx, next_idx, steps;
        regs   = '{default: 32'd0};
        pc_idx = 0;
        steps  = 0;
        while (pc_idx != 199) begin
            word     = rom[pc_idx[7:0]];
            rs       = word[25:21];
            rt       = word[20:16];
            rd       = word[15:11];
            imm      = {{16{word[15]}}, word[15:0]};
            a        = regs[rs];
            b        = regs[rt];
            addr     = a + imm;
            next_idx = pc_idx + 1;
            case (word[31:26])
                core_pkg::op_rtype: begin
                    case (word[5:0])
                        core_pkg::fn_addu: res = a + b;
                        core_pkg::fn_subu: res = a - b;
                        core_pkg::fn_and:  res = a & b;
                        core_pkg::fn_or:   res = a | b;
                        default:           res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    regs[rd] = res;
                end
                core_pkg::op_addiu: regs[rt] = addr;
                core_pkg::op_lw:    regs[rt] = model_mem[addr[8:2]];
                core_pkg::op_sw: begin
                    model_mem[addr[8:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                core_pkg::op_beq: begin
                    if (a == b)
                        next_idx = pc_idx + 1 + $signed(imm);
                end
                default: ;
            endcase
            regs[0] = 32'd0;  // r0 stays zero
            pc_idx  = next_idx;
            steps++;
            if (steps > 1000)
                fail_run("reference model never reached the final loop");
        end
    endtask

    task automatic wait_store(output logic [31:0] addr, output logic [31:0] data);
        logic seen;
        int   waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen) begin
            @(posedge clock);
            if (d_valid && d_ready && d_req.write) begin
                seen = 1'b1;
                addr = d_req.addr;
                data = d_req.wdata;
            end else begin
                waited++;
                if (waited >= 2000)
                    fail_run("no store reached the data port within 2000 cycles");
            end
        end
    endtask

    // rom and data memory answer combinationally
    assign inst_rdata = (inst_addr < 32'd1024) ? rom[inst_addr[9:2]] : 32'd0;
    assign d_rdata    = dmem[d_req.addr[8:2]];

    always @(negedge clock) begin
        d_ready <= rand_below(10) < 6;  // ready about 60% of cycles
    end

    always @(posedge clock) begin
        if (rst_n && d_valid && d_ready && d_req.write)
            dmem[d_req.addr[8:2]] <= d_req.wdata;
    end

    initial begin
        logic [31:0] got_addr, got_data;
        seed       = 32'h6b8c;
        clock      = 1'b0;
        rst_n      = 1'b0;
        d_ready    = 1'b0;
        for (int i = 0; i < 128; i++) begin
            dmem[i[6:0]]      = fill_word(i[6:0]);
            model_mem[i[6:0]] = fill_word(i[6:0]);
        end
        build_program();
        run_model();
        $display("expecting %0d stores", exp_addr.size());

        repeat (10) @(posedge clock);
        check("reset d_valid", 32'd0, {31'd0, d_valid});
        check("reset inst_addr", 32'd0, inst_addr);
        @(negedge clock);
        rst_n = 1'b1;

        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_store(got_addr, got_data);
            check($sformatf("store %0d address", k), exp_addr[k], got_addr);
            check($sformatf("store %0d data", k), exp_data[k], got_data);
        end

        // the core now spins on the final beq, so no store may follow
        repeat (100) begin
            @(posedge clock);
            if (d_valid && d_ready && d_req.write)
                fail_run("a store arrived after the last expected one");
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== src.f ====
hw/core_pkg.sv
hw/core_if.sv
hw/core_id.sv
hw/core_ex.sv
hw/core_branch.sv
hw/core_forward.sv
hw/core_hazard.sv
hw/core_mem.sv
hw/core.sv
tests/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -Mdir obj_dir -f src.f

./obj_dir/Vtb_core
